//--- Bender.yml
package:
  name: ps_frag_tx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ps_frag_pkg.sv
      - hdl/ps_scfifo.sv
      - hdl/ps_fragmenter.sv
      - hdl/ps_frag_header.sv
      - hdl/ps_frag_tx.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/ps_frag_tx_tb.sv

//--- hdl/ps_frag_defines.svh
// ------------------------------
// stream, fragment and FIFO sizing macros
// for the fragmenter transmit path
// ------------------------------

`ifndef PS_FRAG_DEFINES_SVH
`define PS_FRAG_DEFINES_SVH

// stream word width
`define PS_WIDTH 16

// max payload words per fragment
`define PS_LENGTH 8

// length-minus-one field, ceil log2 of PS_LENGTH
`define PS_LEN_W $clog2(`PS_LENGTH)

// per-packet fragment sequence number
`define PS_SEQ_W 7

// depth of both fragmenter buffers, one fragment plus slack
`define PS_FIFO_DEPTH (`PS_LENGTH + 2)

`endif

//--- hdl/ps_frag_header.sv
// ------------------------------
// header inserter FSM
// numbers fragments, one header word then payload
// ------------------------------

`include "ps_frag_defines.svh"

module ps_frag_header (
    // reset and clock
    input  logic                  reset,
    input  logic                  clk,

    // buffered fragment stream
    input  ps_frag_pkg::ps_word_t i_dat,
    input  logic                  i_val,
    input  logic                  i_eop,
    input  ps_frag_pkg::ps_len_t  i_len,   // steady per fragment
    input  logic                  i_fin,
    output logic                  i_rdy,

    // output stream with headers
    output ps_frag_pkg::ps_word_t o_dat,
    output logic                  o_val,
    output logic                  o_eop,
    input  logic                  o_rdy
);
    import ps_frag_pkg::*;

    // zero gap between sequence and length fields
    localparam int unsigned HDR_PAD = `PS_WIDTH - 1 - `PS_SEQ_W - `PS_LEN_W;

    ps_hdr_state_e state;
    ps_seq_t       seq;        // fragment number in packet
    ps_frag_kind_e kind;
    ps_word_t      hdr_word;
    logic          hdr_acc;    // header taken by sink
    logic          eop_acc;    // last payload word taken

    // ------------------------------
    // header word
    // ------------------------------
    assign kind     = i_fin ? FRAG_LAST : FRAG_MID;
    assign hdr_word = {kind, seq, {HDR_PAD{1'b0}}, i_len}; // kind | seq | 0 | len

    assign hdr_acc = (state == HDR_HEADER)  & i_val & o_rdy;
    assign eop_acc = (state == HDR_PAYLOAD) & i_val & o_rdy & i_eop;

    // output mux
    always_comb begin
        o_val = i_val;              // header only once fragment is buffered
        case (state)
            HDR_PAYLOAD: begin
                o_dat = i_dat;
                o_eop = i_eop;
                i_rdy = o_rdy;      // straight pass-through
            end
            default: begin
                o_dat = hdr_word;
                o_eop = 1'b0;
                i_rdy = 1'b0;       // hold payload behind header
            end
        endcase
    end

    // ------------------------------
    // state and sequence
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= HDR_HEADER;
        end else begin
            case (state)
                HDR_HEADER:
                    if (hdr_acc)
                        state <= HDR_PAYLOAD;
                HDR_PAYLOAD:
                    if (eop_acc)
                        state <= HDR_HEADER;
                default:
                    state <= HDR_HEADER;
            endcase
        end
    end

    // next fragment number, restart per packet
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            seq <= '0;
        else if (eop_acc)
            seq <= (kind == FRAG_LAST) ? '0 : ps_seq_t'(seq + 1'b1);
    end

    // ------------------------------
    // checks
    // ------------------------------
    // stalled output holds, header and payload alike
    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        o_val && !o_rdy |=> o_val && $stable(o_dat)
    ) else $error("ps_frag_header: output changed while stalled");

endmodule: ps_frag_header

//--- hdl/ps_frag_pkg.sv
// ------------------------------
// shared types of the fragmenter path
// word, length, sequence, header state and fragment kind
// ------------------------------

`include "ps_frag_defines.svh"

package ps_frag_pkg;

    // stream word
    typedef logic [`PS_WIDTH - 1 : 0] ps_word_t;

    // fragment length minus one
    typedef logic [`PS_LEN_W - 1 : 0] ps_len_t;

    // fragment number within a packet, wraps to zero
    typedef logic [`PS_SEQ_W - 1 : 0] ps_seq_t;

    // header bit 15
    typedef enum logic {
        FRAG_MID  = 1'b0,   // more fragments follow
        FRAG_LAST = 1'b1    // closes the packet
    } ps_frag_kind_e;

    // header inserter FSM
    typedef enum logic {
        HDR_HEADER  = 1'b0, // header word on output
        HDR_PAYLOAD = 1'b1  // payload pass-through
    } ps_hdr_state_e;

endpackage: ps_frag_pkg

//--- hdl/ps_frag_tx.sv
// ------------------------------
// fragmentation transmit top
// fragmenter followed by header inserter
// ------------------------------

module ps_frag_tx (
    // reset and clock
    input  logic                  reset,
    input  logic                  clk,

    // packet input
    input  ps_frag_pkg::ps_word_t i_dat,
    input  logic                  i_val,
    input  logic                  i_eop,
    output logic                  i_rdy,

    // header plus fragment output
    output ps_frag_pkg::ps_word_t o_dat,
    output logic                  o_val,
    output logic                  o_eop,
    input  logic                  o_rdy
);
    import ps_frag_pkg::*;

    // ------------------------------
    // fragment link
    // ------------------------------
    ps_word_t f_dat;
    logic     f_val;    // whole fragment buffered
    logic     f_eop;    // fragment end
    logic     f_rdy;
    ps_len_t  f_len;    // length minus one
    logic     f_fin;    // packet end

    ps_fragmenter u_fragmenter (
        .reset (reset),
        .clk   (clk),
        .i_dat (i_dat),
        .i_val (i_val),
        .i_eop (i_eop),
        .i_rdy (i_rdy),
        .o_len (f_len),
        .o_fin (f_fin),
        .o_dat (f_dat),
        .o_val (f_val),
        .o_eop (f_eop),
        .o_rdy (f_rdy)
    );

    ps_frag_header u_frag_header (
        .reset (reset),
        .clk   (clk),
        .i_dat (f_dat),
        .i_val (f_val),
        .i_eop (f_eop),
        .i_len (f_len),
        .i_fin (f_fin),
        .i_rdy (f_rdy),
        .o_dat (o_dat),
        .o_val (o_val),
        .o_eop (o_eop),
        .o_rdy (o_rdy)
    );

endmodule: ps_frag_tx

//--- hdl/ps_fragmenter.sv
// ------------------------------
// cuts input packets into fragments of up to PS_LENGTH words
// payload and length/last side info in two FIFOs
// ------------------------------

`include "ps_frag_defines.svh"

module ps_fragmenter (
    // reset and clock
    input  logic                  reset,
    input  logic                  clk,

    // input stream
    input  ps_frag_pkg::ps_word_t i_dat,
    input  logic                  i_val,
    input  logic                  i_eop,
    output logic                  i_rdy,

    // side info, steady over the whole fragment
    output ps_frag_pkg::ps_len_t  o_len,   // length minus one
    output logic                  o_fin,   // last fragment of packet

    // fragment stream, o_val only once fragment is complete
    output ps_frag_pkg::ps_word_t o_dat,
    output logic                  o_val,
    output logic                  o_eop,
    input  logic                  o_rdy
);
    import ps_frag_pkg::*;

    ps_len_t len_cnt;   // words so far in current fragment, minus one
    logic    i_eof;     // PS_LENGTH-th word of a fragment
    logic    in_acc;    // input transfer
    logic    len_wr;    // fragment closed this cycle
    logic    len_rdy;
    logic    dat_val;

    assign in_acc = i_val & i_rdy;
    assign i_eof  = (len_cnt == ps_len_t'(`PS_LENGTH - 1));
    assign len_wr = in_acc & (i_eop | i_eof);

    // ------------------------------
    // fragment length counter
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            len_cnt <= '0;
        else if (in_acc)
            len_cnt <= (i_eop | i_eof) ? '0 : len_cnt + 1'b1; // restart on any cut
    end

    // payload, eop marks the fragment cut
    ps_scfifo #(
        .DWIDTH (`PS_WIDTH),
        .DEPTH  (`PS_FIFO_DEPTH)
    ) dat_buffer (
        .reset  (reset),
        .clk    (clk),
        .i_dat  (i_dat),
        .i_val  (i_val),
        .i_eop  (i_eop | i_eof),
        .i_rdy  (i_rdy),            // back-pressure only when full
        .o_dat  (o_dat),
        .o_val  (dat_val),
        .o_eop  (o_eop),
        .o_rdy  (o_val & o_rdy)     // pop only a complete fragment
    );

    // one entry per fragment, eop slot carries the packet end
    ps_scfifo #(
        .DWIDTH (`PS_LEN_W),
        .DEPTH  (`PS_FIFO_DEPTH)
    ) len_buffer (
        .reset  (reset),
        .clk    (clk),
        .i_dat  (len_cnt),
        .i_val  (len_wr),
        .i_eop  (i_eop),
        .i_rdy  (len_rdy),
        .o_dat  (o_len),
        .o_val  (o_val),
        .o_eop  (o_fin),
        .o_rdy  (o_val & o_rdy & o_eop) // retire on eop word
    );

    // ------------------------------
    // checks
    // ------------------------------
    a_len_no_refuse: assert property (
        @(posedge clk) disable iff (reset)
        len_wr |-> len_rdy
    ) else $error("ps_fragmenter: length FIFO refused a fragment");

    // a listed fragment always has its payload buffered
    a_len_has_dat: assert property (
        @(posedge clk) disable iff (reset)
        o_val |-> dat_val
    ) else $error("ps_fragmenter: length entry without payload");

endmodule: ps_fragmenter

//--- hdl/ps_scfifo.sv
// ------------------------------
// show-ahead single-clock FIFO
// data word plus eop flag, register array
// ------------------------------

module ps_scfifo
#(
    parameter int unsigned DWIDTH = 8,  // payload width
    parameter int unsigned DEPTH  = 10  // words
)
(
    // reset and clock
    input  logic                  reset,
    input  logic                  clk,

    // write side
    input  logic [DWIDTH - 1 : 0] i_dat,
    input  logic                  i_val,
    input  logic                  i_eop,
    output logic                  i_rdy,

    // read side, o_rdy acts as pop strobe
    output logic [DWIDTH - 1 : 0] o_dat,
    output logic                  o_val,
    output logic                  o_eop,
    input  logic                  o_rdy
);
    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CW = $clog2(DEPTH + 1);
    localparam logic [AW - 1 : 0] PTR_LAST = AW'(DEPTH - 1);
    localparam logic [CW - 1 : 0] CNT_FULL = CW'(DEPTH);

    // ------------------------------
    // storage and pointers
    // ------------------------------
    logic [DWIDTH : 0]     mem [DEPTH];   // {eop, dat}
    logic [AW - 1 : 0]     wr_ptr;
    logic [AW - 1 : 0]     rd_ptr;
    logic [CW - 1 : 0]     count;         // words held
    logic                  wr_en;
    logic                  rd_en;

    assign i_rdy = (count != CNT_FULL);  // low only while full
    assign o_val = (count != '0);
    assign wr_en = i_val & i_rdy;
    assign rd_en = o_rdy & o_val;        // guarded pop

    // payload array, no reset
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= {i_eop, i_dat};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            wr_ptr <= '0;
        else if (wr_en)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1; // wrap at DEPTH
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rd_ptr <= '0;
        else if (rd_en)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
    end

    // occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or simultaneous
            endcase
        end
    end

    // show-ahead output, head word straight from array
    assign o_dat = mem[rd_ptr][DWIDTH - 1 : 0];
    assign o_eop = mem[rd_ptr][DWIDTH];

    // ------------------------------
    // checks
    // ------------------------------
    // occupancy never runs past the array
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        (count == CNT_FULL) && !rd_en |=> (count == CNT_FULL) && (wr_ptr == rd_ptr)
    ) else $error("ps_scfifo: write taken while full");

    // pop strobe from the consumer only when a word is shown
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        o_rdy |-> o_val
    ) else $error("ps_scfifo: read strobe while empty");

endmodule: ps_scfifo

//--- src.f
+incdir+hdl
hdl/ps_frag_pkg.sv
hdl/ps_scfifo.sv
hdl/ps_fragmenter.sv
hdl/ps_frag_header.sv
hdl/ps_frag_tx.sv
test/ps_frag_tx_tb.sv

//--- test/ps_frag_tx_input.txt
// columns in hex: test id, packet length, back-pressure mode, expected fragments
// mode 0 open sink and no input gaps, 1 random sink, 2 low bursts
// the mode 0 run at the top is sent back to back
01 001 0 01
02 005 0 01
03 007 0 01
04 008 0 01
05 009 0 02
06 010 0 02
07 011 0 03
08 003 0 01
09 028 1 05
0a 00c 1 02
0b 041 2 09
0c 001 2 01
0d 0ff 1 20
0e 00f 2 02
0f 020 0 04
10 002 1 01
11 408 2 81
12 009 1 02

//--- test/ps_frag_tx_tb.sv
// ------------------------------
// testbench for the fragmentation transmit top
// file-driven packets, LCG payload and back-pressure
// model queue of headers and payload, cycle timeout
// ------------------------------

`include "ps_frag_defines.svh"

module ps_frag_tx_tb;
    import ps_frag_pkg::*;

    localparam int          MAX_TESTS = 64;
    localparam logic [31:0] SEED      = 32'h1808;

    // one expected output word, header or payload
    typedef struct packed {
        logic          is_hdr;
        logic          eop;
        ps_frag_kind_e kind;     // kind of the owning fragment
        ps_seq_t       seq;
        ps_len_t       len;
        ps_word_t      dat;
        logic [15:0]   pkt;      // test index
        logic [15:0]   frag;
    } exp_t;

    // one input word
    typedef struct packed {
        ps_word_t   dat;
        logic       eop;
        logic [1:0] mode;        // sink pattern while it is sent
    } stim_t;

    logic        clk;
    logic        reset;
    ps_word_t    i_dat;
    logic        i_val;
    logic        i_eop;
    logic        i_rdy;
    ps_word_t    o_dat;
    logic        o_val;
    logic        o_eop;
    logic        o_rdy;

    logic [15:0] tvec [4 * MAX_TESTS];   // id, length, mode, fragments
    exp_t        exp_q [$];
    stim_t       stim_q [$];
    int          frag_exp [MAX_TESTS];
    int          frag_seen [MAX_TESTS];
    int          num_tests;
    int          cycles;
    int          cycle_limit;
    int          value_errs;
    int          other_errs;
    logic [1:0]  cur_mode;               // 0 open, 1 random, 2 bursts

    ps_frag_tx UUT (
        .reset (reset),
        .clk   (clk),
        .i_dat (i_dat),
        .i_val (i_val),
        .i_eop (i_eop),
        .i_rdy (i_rdy),
        .o_dat (o_dat),
        .o_val (o_val),
        .o_eop (o_eop),
        .o_rdy (o_rdy)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------
    // stimulus and model
    // ------------------------------
    task automatic load_tests();
        for (int i = 0; i < 4 * MAX_TESTS; i++)
            tvec[i] = 16'hffff;          // end marker
        $readmemh("test/ps_frag_tx_input.txt", tvec);
        num_tests = 0;
        while (num_tests < MAX_TESTS && tvec[4 * num_tests] != 16'hffff)
            num_tests++;
    endtask

    task automatic build_model();
        logic [31:0] st;
        int          len;
        int          flen;
        exp_t        e;
        stim_t       s;
        st = SEED;
        for (int t = 0; t < num_tests; t++) begin
            len = int'(tvec[4 * t + 1]);
            frag_exp[t] = int'(tvec[4 * t + 3]);
            for (int f = 0; f * `PS_LENGTH < len; f++) begin
                flen = len - f * `PS_LENGTH;
                if (flen > `PS_LENGTH)
                    flen = `PS_LENGTH;   // full fragment
                e = '0;
                e.is_hdr = 1'b1;
                e.kind = ((f + 1) * `PS_LENGTH >= len) ? FRAG_LAST : FRAG_MID;
                e.seq = ps_seq_t'(f);    // wraps like the header field
                e.len = ps_len_t'(flen - 1);
                e.pkt = 16'(t);
                e.frag = 16'(f);
                exp_q.push_back(e);
                e.is_hdr = 1'b0;
                for (int w = 0; w < flen; w++) begin
                    st = lcg_step(st);
                    e.dat = st[31:16];
                    e.eop = (w == flen - 1);  // fragment end on output
                    exp_q.push_back(e);
                    s.dat = e.dat;
                    s.eop = e.eop && (e.kind == FRAG_LAST); // packet end on input
                    s.mode = tvec[4 * t + 2][1:0];
                    stim_q.push_back(s);
                end
            end
        end
    endtask

    task automatic drive_packets();
        logic [31:0] st;
        logic        taken;
        stim_t       s;
        st = lcg_step(SEED);             // own stream for input gaps
        foreach (stim_q[k]) begin
            s = stim_q[k];
            cur_mode <= s.mode;
            st = lcg_step(st);
            if (s.mode != 2'd0 && st[31:30] == 2'b00) begin
                i_val <= 1'b0;           // one idle cycle
                @(posedge clk);
            end
            i_dat <= s.dat;
            i_val <= 1'b1;
            i_eop <= s.eop;
            do begin
                @(negedge clk);
                taken = i_rdy;           // steady until next edge
                @(posedge clk);
            end while (!taken);
        end
        i_val <= 1'b0;
        i_eop <= 1'b0;
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_word(input string name, input ps_word_t exp_dat,
                              input ps_word_t act_dat, input logic exp_eop,
                              input logic act_eop);
        if (act_dat !== exp_dat) begin
            value_errs++;
            $display("error %s data: expected %h actual %h", name, exp_dat, act_dat);
        end
        if (act_eop !== exp_eop) begin
            value_errs++;
            $display("error %s eop: expected %b actual %b", name, exp_eop, act_eop);
        end
    endtask

    task automatic check_header(input string name, input ps_frag_kind_e exp_kind,
                                input ps_seq_t exp_seq, input ps_len_t exp_len,
                                input ps_word_t act, input logic act_eop);
        ps_frag_kind_e act_kind;
        ps_seq_t       act_seq;
        ps_len_t       act_len;
        act_kind = ps_frag_kind_e'(act[15]);   // kind | seq | zero | len
        act_seq  = act[14:8];
        act_len  = act[2:0];
        if (act_kind !== exp_kind) begin
            value_errs++;
            $display("error %s kind: expected %s actual %s", name, exp_kind.name(),
                     act_kind.name());
        end
        if (act_seq !== exp_seq) begin
            value_errs++;
            $display("error %s seq: expected %0d actual %0d", name, exp_seq, act_seq);
        end
        if (act_len !== exp_len) begin
            value_errs++;
            $display("error %s len: expected %0d actual %0d", name, exp_len, act_len);
        end
        if (act[7:3] !== 5'b0) begin
            value_errs++;
            $display("error %s padding: expected 00 actual %h", name, act[7:3]);
        end
        if (act_eop !== 1'b0) begin
            value_errs++;
            $display("error %s eop: expected 0 actual %b", name, act_eop);
        end
    endtask

    task automatic match_frag_count(input string name, input int exp_cnt, input int act_cnt);
        if (act_cnt != exp_cnt) begin
            value_errs++;
            $display("error %s fragments: expected %0d actual %0d", name, exp_cnt, act_cnt);
        end
    endtask

    // ------------------------------
    // clock, sink, monitor
    // ------------------------------
    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : sink
        logic [31:0] st;
        int          burst;
        st = lcg_step(lcg_step(SEED));  // third stream
        burst = 0;
        o_rdy = 1'b0;
        forever begin
            @(posedge clk);
            st = lcg_step(st);
            case (cur_mode)
                2'd1: o_rdy <= st[31];  // coin flip
                2'd2: begin
                    if (burst > 0) begin
                        burst--;
                        o_rdy <= 1'b0;
                    end else if (st[31:29] == 3'b000) begin
                        burst = int'(st[27:25]) + 1; // low for 2 to 9 cycles
                        o_rdy <= 1'b0;
                    end else begin
                        o_rdy <= 1'b1;
                    end
                end
                default: o_rdy <= 1'b1;
            endcase
        end
    end

    initial begin : monitor
        exp_t     e;
        logic     held;
        ps_word_t held_dat;
        logic     held_eop;
        string    name;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                held = 1'b0;
            end else begin
                // a stalled word must still be there
                if (held && !(o_val === 1'b1 && o_dat === held_dat && o_eop === held_eop)) begin
                    other_errs++;
                    $display("output word %h was dropped or changed while the sink stalled",
                             held_dat);
                end
                held = o_val && !o_rdy;
                held_dat = o_dat;
                held_eop = o_eop;
                if (o_val && o_rdy) begin
                    if (exp_q.size() == 0) begin
                        other_errs++;
                        $display("extra output word %h arrived after all expected words",
                                 o_dat);
                    end else begin
                        e = exp_q.pop_front();
                        name = $sformatf("test %0h frag %0d", tvec[4 * e.pkt], e.frag);
                        if (e.is_hdr) begin
                            check_header({name, " header"}, e.kind, e.seq, e.len, o_dat, o_eop);
                        end else begin
                            if (o_eop === 1'b1)
                                frag_seen[e.pkt]++;   // fragment closed on the output
                            check_word(name, e.dat, o_dat, e.eop, o_eop);
                            if (e.eop && e.kind == FRAG_LAST)
                                match_frag_count(name, frag_exp[e.pkt], frag_seen[e.pkt]);
                        end
                    end
                end
            end
        end
    end

    // ------------------------------
    // run control
    // ------------------------------
    initial begin : main
        value_errs = 0;
        other_errs = 0;
        cycles = 0;
        reset = 1'b1;
        i_dat = '0;
        i_val = 1'b0;
        i_eop = 1'b0;
        cur_mode = 2'd0;
        load_tests();
        build_model();
        if (num_tests == 0) begin
            other_errs++;
            $display("no test packets were read from the input file");
        end
        cycle_limit = 4 * exp_q.size() + 200;  // words plus headers
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        fork
            drive_packets();
        join_none
        @(negedge clk);
        // idle state right after reset
        if (i_rdy !== 1'b1 || o_val !== 1'b0) begin
            other_errs++;
            $display("after reset the input was not ready or the output was already valid");
        end
        while (exp_q.size() != 0 && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        repeat (20) @(posedge clk);  // room for stray extra words
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("timeout after %0d cycles, %0d expected words never appeared",
                     cycles, exp_q.size());
        end
        $display("tests %0d, value errors %0d, other errors %0d",
                 num_tests, value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule: ps_frag_tx_tb
